/* Bender.yml */
package:
  name: issue_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/reg_scoreboard.sv
      - rtl/wb_pipe.sv
      - rtl/issue_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_issue.sv

/* rtl/instr_decoder.sv */
module instr_decoder
(
	input  issue_pkg::instr_t   instr,
	output logic                has_ra,
	output logic                has_rb,
	output logic                has_rt,
	output issue_pkg::reg_idx_t ra,
	output issue_pkg::reg_idx_t rb,
	output issue_pkg::reg_idx_t rt
);

	issue_pkg::opcode_t opcode;
	logic               uses_rt;

	// Register fields sit at fixed positions for every opcode
	assign opcode = issue_pkg::opcode_t'(instr[23:20]);
	assign rt     = instr[17:12];
	assign ra     = instr[11:6];
	assign rb     = instr[5:0];

	// Per-opcode use flags
	// Unknown encodings fall into the default arm and use nothing
	always_comb
	begin
		has_ra  = 1'b0;
		has_rb  = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			issue_pkg::OP_LI:
			begin
				uses_rt = 1'b1;
			end
			issue_pkg::OP_MOV:
			begin
				uses_rt = 1'b1;
				has_ra  = 1'b1;
			end
			issue_pkg::OP_ADD:
			begin
				uses_rt = 1'b1;
				has_ra  = 1'b1;
				has_rb  = 1'b1;
			end
			issue_pkg::OP_ST:
			begin
				has_ra = 1'b1;
				has_rb = 1'b1;
			end
			default:
			begin
				uses_rt = 1'b0;
			end
		endcase
	end

	// A write to r0 is thrown away, so r0 is never reported as a target
	// This keeps r0 out of the scoreboard clear and out of the writeback pipe
	assign has_rt = uses_rt && (rt != '0);

endmodule

/* rtl/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// ========================================
// Issue stage configuration
// ========================================

// Number of architectural registers, r0 included
`define ISSUE_NUM_REGS 64

// Width of a register index, log2 of the register count
`define ISSUE_REG_W 6

// Width of one instruction word as offered to the issue stage
`define ISSUE_INSTR_W 24

// Cycles from the issue cycle to the writeback cycle
// This is also the depth of the writeback delay line
`define ISSUE_EXEC_STAGES 3

`endif

/* rtl/issue_pkg.sv */
`include "issue_cfg.svh"

package issue_pkg;

	// ========================================
	// Register and instruction types
	// ========================================

	// Number of one architectural register
	typedef logic [`ISSUE_REG_W-1:0] reg_idx_t;

	// One bit per architectural register, bit n stands for rn
	typedef logic [`ISSUE_NUM_REGS-1:0] regs_bitmap_t;

	// Raw instruction word
	// Opcode sits in 23:20, rt in 17:12, ra in 11:6 and rb in 5:0
	// Bits 19:18 are spare and ignored by the decoder
	typedef logic [`ISSUE_INSTR_W-1:0] instr_t;

	// Opcodes known to the issue stage
	// Any other encoding behaves as a NOP
	typedef enum logic [3:0]
	{
		OP_NOP = 4'h0,
		OP_LI  = 4'h1,
		OP_MOV = 4'h2,
		OP_ADD = 4'h3,
		OP_ST  = 4'h4
	} opcode_t;

endpackage

/* rtl/issue_top.sv */
module issue_top
(
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_v,
	input  issue_pkg::instr_t   instr,
	input  logic                rollback,
	output logic                stall,
	output logic                issued,
	output logic                wb_v,
	output issue_pkg::reg_idx_t wb_rt
);

	// Decoded register fields
	logic                    has_ra;
	logic                    has_rb;
	logic                    has_rt;
	issue_pkg::reg_idx_t     ra;
	issue_pkg::reg_idx_t     rb;
	issue_pkg::reg_idx_t     rt;
	// Targets still in flight, consumed only during rollback
	issue_pkg::regs_bitmap_t inflight_bitmap;

	instr_decoder i_instr_decoder
	(
		.instr  (instr),
		.has_ra (has_ra),
		.has_rb (has_rb),
		.has_rt (has_rt),
		.ra     (ra),
		.rb     (rb),
		.rt     (rt)
	);

	reg_scoreboard i_reg_scoreboard
	(
		.clk             (clk),
		.rst             (rst),
		.instr_v         (instr_v),
		.has_ra          (has_ra),
		.has_rb          (has_rb),
		.has_rt          (has_rt),
		.ra              (ra),
		.rb              (rb),
		.rt              (rt),
		.wb_v            (wb_v),
		.wb_rt           (wb_rt),
		.rollback        (rollback),
		.rollback_bitmap (inflight_bitmap),
		.issued          (issued),
		.stall           (stall)
	);

	wb_pipe i_wb_pipe
	(
		.clk             (clk),
		.rst             (rst),
		.issued          (issued),
		.has_rt          (has_rt),
		.rt              (rt),
		.rollback        (rollback),
		.wb_v            (wb_v),
		.wb_rt           (wb_rt),
		.inflight_bitmap (inflight_bitmap)
	);

endmodule

/* rtl/reg_scoreboard.sv */
module reg_scoreboard
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instr_v,
	input  logic                    has_ra,
	input  logic                    has_rb,
	input  logic                    has_rt,
	input  issue_pkg::reg_idx_t     ra,
	input  issue_pkg::reg_idx_t     rb,
	input  issue_pkg::reg_idx_t     rt,
	input  logic                    wb_v,
	input  issue_pkg::reg_idx_t     wb_rt,
	input  logic                    rollback,
	input  issue_pkg::regs_bitmap_t rollback_bitmap,
	output logic                    issued,
	output logic                    stall
);

	// One current valid bit per register
	issue_pkg::regs_bitmap_t valid;
	// Valid bits as seen by this cycle's issue check
	issue_pkg::regs_bitmap_t nxt_valid;
	issue_pkg::regs_bitmap_t valid_d;
	issue_pkg::regs_bitmap_t srcs;
	issue_pkg::regs_bitmap_t tgts;
	issue_pkg::regs_bitmap_t wbs;
	issue_pkg::regs_bitmap_t set_bm;
	issue_pkg::regs_bitmap_t clr_bm;

	// ========================================
	// Bitmaps built from the current instruction
	// ========================================

	// Sources that must be valid before the instruction may go
	always_comb
	begin
		srcs = '0;
		if (has_ra)
			srcs[ra] = 1'b1;
		if (has_rb)
			srcs[rb] = 1'b1;
		// r0 never waits on anything
		srcs[0] = 1'b0;
	end

	// Target that turns busy once the instruction issues
	// The decoder already drops r0 as a target
	always_comb
	begin
		tgts = '0;
		if (has_rt)
			tgts[rt] = 1'b1;
	end

	// Register coming back from the writeback pipe this cycle
	always_comb
	begin
		wbs = '0;
		if (wb_v)
			wbs[wb_rt] = 1'b1;
	end

	// ========================================
	// Valid bitmap update
	// ========================================

	// Writebacks and the rollback set both make registers valid again
	assign set_bm = wbs | (rollback ? rollback_bitmap : '0);
	assign clr_bm = issued ? tgts : '0;

	// Sets are visible to the issue check in the same cycle
	// A consumer may therefore issue in its producer's writeback cycle
	assign nxt_valid = valid | set_bm;

	// A clear from a new issue beats a set of the same register
	// The new owner of the register is still in flight after this edge
	assign valid_d = nxt_valid & ~clr_bm;

	always_ff @(posedge clk)
	begin
		if (rst)
			valid <= '1;
		else
			valid <= valid_d;
	end

	// ========================================
	// Issue decision
	// ========================================

	// Every used source must be valid, and nothing goes in a rollback cycle
	assign issued = instr_v && !rollback && ((nxt_valid & srcs) == srcs);

	// The source holds the instruction until it issues
	assign stall = instr_v && !issued;

	// ========================================
	// Checks
	// ========================================

	// r0 can never be marked busy
	a_r0_valid : assert property (@(posedge clk) disable iff (rst) valid[0]);

	// The decoder masks r0 targets, so the pipe must never return r0
	a_wb_not_r0 : assert property (@(posedge clk) disable iff (rst)
		wb_v |-> (wb_rt != '0));

endmodule

/* rtl/wb_pipe.sv */
`include "issue_cfg.svh"

module wb_pipe
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    issued,
	input  logic                    has_rt,
	input  issue_pkg::reg_idx_t     rt,
	input  logic                    rollback,
	output logic                    wb_v,
	output issue_pkg::reg_idx_t     wb_rt,
	output issue_pkg::regs_bitmap_t inflight_bitmap
);

	localparam int STAGES = `ISSUE_EXEC_STAGES;

	// One entry per execution cycle
	// Entry 0 is loaded at the issue edge and the last entry writes back
	logic                stage_v  [STAGES];
	issue_pkg::reg_idx_t stage_rt [STAGES];

	// ========================================
	// Delay line
	// ========================================

	// Valid bits are control state and are cleared on reset and on rollback
	// Every entry is dropped on rollback except the last one, whose
	// writeback is already on the output during the rollback cycle
	always_ff @(posedge clk)
	begin
		if (rst || rollback)
		begin
			for (int i = 0; i < STAGES; i++)
				stage_v[i] <= 1'b0;
		end
		else
		begin
			// Only instructions with a real target return a writeback
			stage_v[0] <= issued && has_rt;
			for (int i = 1; i < STAGES; i++)
				stage_v[i] <= stage_v[i-1];
		end
	end

	// Target numbers just follow their valid bits down the line
	always_ff @(posedge clk)
	begin
		stage_rt[0] <= rt;
		for (int i = 1; i < STAGES; i++)
			stage_rt[i] <= stage_rt[i-1];
	end

	assign wb_v  = stage_v[STAGES-1];
	assign wb_rt = stage_rt[STAGES-1];

	// ========================================
	// In-flight set for rollback
	// ========================================

	// Targets that will not write back this cycle
	// The last entry is left out because its writeback sets the bit anyway
	always_comb
	begin
		inflight_bitmap = '0;
		for (int i = 0; i < STAGES - 1; i++)
		begin
			if (stage_v[i])
				inflight_bitmap[stage_rt[i]] = 1'b1;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// The scoreboard blocks issue during a rollback
	// A load in that cycle would be lost by the flush
	a_no_issue_on_rollback : assert property (@(posedge clk) disable iff (rst)
		!(rollback && issued));

endmodule

/* sim/tb_issue.sv */
`include "issue_cfg.svh"

module tb_issue;

	localparam int STAGES   = `ISSUE_EXEC_STAGES;
	localparam int NUM_ROWS = 19;
	localparam int NUM_RAND = 40;
	// Each instruction waits at most one full execution latency
	localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RAND) * (STAGES + 4);

	logic                clk;
	logic                rst;
	logic                instr_v;
	issue_pkg::instr_t   instr;
	logic                rollback;
	logic                stall;
	logic                issued;
	logic                wb_v;
	issue_pkg::reg_idx_t wb_rt;

	// Directed stimulus table with one row per instruction
	string             row_name   [NUM_ROWS];
	issue_pkg::instr_t row_instr  [NUM_ROWS];
	logic              row_rb     [NUM_ROWS];
	int                row_stalls [NUM_ROWS];

	// Reference model of busy registers with a countdown per in-flight target
	issue_pkg::regs_bitmap_t busy;
	int                      fly_cnt [$];
	issue_pkg::reg_idx_t     fly_rt  [$];
	logic [31:0]             rng;

	issue_top i_issue_top
	(
		.clk      (clk),
		.rst      (rst),
		.instr_v  (instr_v),
		.instr    (instr),
		.rollback (rollback),
		.stall    (stall),
		.issued   (issued),
		.wb_v     (wb_v),
		.wb_rt    (wb_rt)
	);

	always #2 clk = ~clk;

	// Ends a run that stops making progress
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT never finished", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation timed out");
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Field layout is opcode, two spare bits, rt, ra, rb
	function automatic issue_pkg::instr_t make_instr(input logic [3:0] op,
		input issue_pkg::reg_idx_t rt, input issue_pkg::reg_idx_t ra,
		input issue_pkg::reg_idx_t rb);
		return {op, 2'b00, rt, ra, rb};
	endfunction

	task automatic check_bit(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s: expected %0b, actual %0b", name, what, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_reg(input string name, input string what,
		input issue_pkg::reg_idx_t exp, input issue_pkg::reg_idx_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s: expected r%0d, actual r%0d", name, what, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "Register mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("[FAIL] %s stall_cycles: expected %0d, actual %0d", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stall count mismatch");
		end
	endtask

	// ========================================
	// One cycle of stimulus and reference model
	// ========================================

	// Inputs change on the falling edge and outputs are compared one unit later
	task automatic run_cycle(input string name, input logic v, input issue_pkg::instr_t word,
		input logic rb, output logic did_issue);
		issue_pkg::regs_bitmap_t set_bm;
		issue_pkg::regs_bitmap_t ready;
		issue_pkg::reg_idx_t     exp_rt;
		logic                    exp_wb;
		logic                    exp_issued;
		logic                    use_ra;
		logic                    use_rb;
		logic                    use_rt;
		@(negedge clk);
		instr_v  = v;
		instr    = word;
		rollback = rb;
		#1;
		// Unknown opcodes use no registers, and a write to r0 is no target
		use_ra = word[23:20] inside {issue_pkg::OP_MOV, issue_pkg::OP_ADD, issue_pkg::OP_ST};
		use_rb = word[23:20] inside {issue_pkg::OP_ADD, issue_pkg::OP_ST};
		use_rt = (word[23:20] inside {issue_pkg::OP_LI, issue_pkg::OP_MOV, issue_pkg::OP_ADD})
			&& (word[17:12] != 0);
		// A countdown at zero writes back now and the rest come back only on rollback
		exp_wb = 1'b0;
		exp_rt = '0;
		set_bm = '0;
		for (int i = 0; i < fly_cnt.size(); i++)
		begin
			if (fly_cnt[i] == 0)
			begin
				exp_wb = 1'b1;
				exp_rt = fly_rt[i];
				set_bm[fly_rt[i]] = 1'b1;
			end
			else if (rb)
				set_bm[fly_rt[i]] = 1'b1;
		end
		// Registers freed in this cycle already count as ready
		ready = ~busy | set_bm;
		exp_issued = v && !rb;
		if (use_ra && !ready[word[11:6]])
			exp_issued = 1'b0;
		if (use_rb && !ready[word[5:0]])
			exp_issued = 1'b0;
		check_bit(name, "issued", exp_issued, issued);
		check_bit(name, "stall", v && !exp_issued, stall);
		check_bit(name, "wb_v", exp_wb, wb_v);
		if (exp_wb)
			check_reg(name, "wb_rt", exp_rt, wb_rt);
		// Advance over the rising edge where a new target stays busy over any set
		busy = busy & ~set_bm;
		for (int i = fly_cnt.size() - 1; i >= 0; i--)
		begin
			if (fly_cnt[i] == 0 || rb)
			begin
				fly_cnt.delete(i);
				fly_rt.delete(i);
			end
			else
				fly_cnt[i]--;
		end
		if (exp_issued && use_rt)
		begin
			busy[word[17:12]] = 1'b1;
			fly_cnt.push_back(STAGES - 1);
			fly_rt.push_back(word[17:12]);
		end
		did_issue = exp_issued;
	endtask

	// Holds one instruction until it issues with rollback only in its first cycle
	task automatic apply_row(input string name, input issue_pkg::instr_t word, input logic rb,
		output int stalls);
		logic done;
		stalls = 0;
		run_cycle(name, 1'b1, word, rb, done);
		while (!done)
		begin
			stalls++;
			run_cycle(name, 1'b1, word, 1'b0, done);
		end
	endtask

	task automatic drain_pipe(input string name, input int n);
		logic done;
		repeat (n) run_cycle(name, 1'b0, '0, 1'b0, done);
	endtask

	task automatic set_row(input int i, input string name, input issue_pkg::instr_t word,
		input logic rb, input int stalls);
		row_name[i]   = name;
		row_instr[i]  = word;
		row_rb[i]     = rb;
		row_stalls[i] = stalls;
	endtask

	// ========================================
	// Directed table
	// ========================================

	task automatic load_table();
		set_row(0, "indep_li_r1", make_instr(issue_pkg::OP_LI, 1, 0, 0), 1'b0, 0);
		set_row(1, "indep_li_r2", make_instr(issue_pkg::OP_LI, 2, 0, 0), 1'b0, 0);
		set_row(2, "indep_add_r3", make_instr(issue_pkg::OP_ADD, 3, 4, 5), 1'b0, 0);
		// Consumers presented right after their producer wait out the latency
		set_row(3, "raw_add_r6", make_instr(issue_pkg::OP_ADD, 6, 3, 1), 1'b0, STAGES - 1);
		set_row(4, "raw_mov_r7", make_instr(issue_pkg::OP_MOV, 7, 6, 0), 1'b0, STAGES - 1);
		set_row(5, "r0_src_add", make_instr(issue_pkg::OP_ADD, 8, 0, 0), 1'b0, 0);
		set_row(6, "r0_tgt_li", make_instr(issue_pkg::OP_LI, 0, 0, 0), 1'b0, 0);
		set_row(7, "r0_tgt_read", make_instr(issue_pkg::OP_MOV, 9, 0, 0), 1'b0, 0);
		// The rt field of ST and NOP is ignored
		set_row(8, "st_no_tgt", make_instr(issue_pkg::OP_ST, 13, 11, 12), 1'b0, 0);
		set_row(9, "st_rt_read", make_instr(issue_pkg::OP_ADD, 14, 13, 13), 1'b0, 0);
		set_row(10, "nop_no_tgt", make_instr(issue_pkg::OP_NOP, 15, 0, 0), 1'b0, 0);
		set_row(11, "nop_rt_read", make_instr(issue_pkg::OP_MOV, 16, 15, 0), 1'b0, 0);
		// Rollback with r20 and r21 in flight lets the reader go one cycle later
		set_row(12, "rb_li_r20", make_instr(issue_pkg::OP_LI, 20, 0, 0), 1'b0, 0);
		set_row(13, "rb_li_r21", make_instr(issue_pkg::OP_LI, 21, 0, 0), 1'b0, 0);
		set_row(14, "rb_read_r20", make_instr(issue_pkg::OP_MOV, 22, 20, 0), 1'b1, 1);
		set_row(15, "rb_read_r21", make_instr(issue_pkg::OP_ADD, 23, 21, 20), 1'b0, 0);
		set_row(16, "rb_nop_pulse", make_instr(issue_pkg::OP_NOP, 0, 0, 0), 1'b1, 1);
		set_row(17, "rb_read_r23", make_instr(issue_pkg::OP_MOV, 24, 23, 0), 1'b0, 0);
		set_row(18, "raw_after_rb", make_instr(issue_pkg::OP_MOV, 26, 24, 0), 1'b0, STAGES - 1);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		int                stalls;
		issue_pkg::instr_t word;
		clk      = 1'b0;
		rst      = 1'b1;
		instr_v  = 1'b0;
		instr    = '0;
		rollback = 1'b0;
		busy     = '0;
		rng      = 32'h3a3b;
		load_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			apply_row(row_name[r], row_instr[r], row_rb[r], stalls);
			check_count(row_name[r], row_stalls[r], stalls);
		end
		drain_pipe("table_drain", STAGES + 1);
		// Only registers r0 to r7 are used so dependencies are frequent
		for (int k = 0; k < NUM_RAND; k++)
		begin
			rng  = xorshift32(rng);
			word = make_instr((rng[2:0] > 3'd5) ? 4'h0 : {1'b0, rng[2:0]},
				{3'b000, rng[10:8]}, {3'b000, rng[13:11]}, {3'b000, rng[16:14]});
			apply_row($sformatf("random_%0d", k), word, rng[21:19] == 3'b000, stalls);
		end
		drain_pipe("random_drain", STAGES + 1);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+rtl
rtl/issue_pkg.sv
rtl/instr_decoder.sv
rtl/reg_scoreboard.sv
rtl/wb_pipe.sv
rtl/issue_top.sv
sim/tb_issue.sv
